// ==== src/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

  // Field widths of the instruction word
  localparam int OP_W = 3;
  localparam int REG_ADDR_W = 2;

  // Size of the general register file
  localparam int NUM_REGS = 4;

  // ALU operations, same encoding as the decode-and-execute block
  typedef enum logic [OP_W-1:0] {
    OP_ADD  = 3'd0,
    OP_SUB  = 3'd1,
    OP_INC  = 3'd2,
    OP_NOR  = 3'd3,
    OP_NAND = 3'd4,
    OP_DIV4 = 3'd5,
    OP_MUL2 = 3'd6,
    OP_MUL  = 3'd7
  } opcode_e;

  // Index into the general register file
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // Instruction word, opcode in the top bits
  // Destination first, then the two sources
  typedef struct packed {
    opcode_e   op;
    reg_addr_t rd;
    reg_addr_t rs;
    reg_addr_t rt;
  } instr_t;

endpackage

`default_nettype wire

// ==== src/core_pkg.sv ====
`default_nettype none

package core_pkg;

  // Datapath width, fixed since the shifters use hard bit positions
  localparam int WORD_W = 4;

  // One register value or ALU result
  typedef logic [WORD_W-1:0] word_t;

  // Controller phases, three per instruction plus the idle wait
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    FETCH = 2'd1,
    EXEC  = 2'd2,
    WB    = 2'd3
  } ctrl_state_e;

  // Writeback request from the controller to the register file
  typedef struct packed {
    logic              we;
    isa_pkg::reg_addr_t addr;
    word_t             data;
  } wb_t;

endpackage

`default_nettype wire

// ==== src/alu_exec.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu_exec (
  input  isa_pkg::opcode_e op,
  input  core_pkg::word_t  rs_val,
  input  core_pkg::word_t  rt_val,
  output core_pkg::word_t  result
);

  // Full width product, only the low word is kept
  logic [2*core_pkg::WORD_W-1:0] prod;

  // One candidate result per operation
  core_pkg::word_t out_add;
  core_pkg::word_t out_sub;
  core_pkg::word_t out_inc;
  core_pkg::word_t out_nor;
  core_pkg::word_t out_nand;
  core_pkg::word_t out_div4;
  core_pkg::word_t out_mul2;
  core_pkg::word_t out_mul;

  // Arithmetic wraps modulo 16, carries are dropped
  assign out_add = rs_val + rt_val;
  assign out_sub = rs_val - rt_val;
  assign out_inc = rs_val + core_pkg::word_t'(1);

  // Bitwise logic on both operands
  assign out_nor  = ~(rs_val | rt_val);
  assign out_nand = ~(rs_val & rt_val);

  // Logical shifts of rs only, zeros shifted in
  assign out_div4 = rs_val >> 2;
  // Top bit of rs falls off
  assign out_mul2 = rs_val << 1;

  assign prod    = rs_val * rt_val;
  assign out_mul = prod[core_pkg::WORD_W-1:0];

  // Opcode decode selects one of the eight results
  always_comb begin
    unique case (op)
      isa_pkg::OP_ADD:  result = out_add;
      isa_pkg::OP_SUB:  result = out_sub;
      isa_pkg::OP_INC:  result = out_inc;
      isa_pkg::OP_NOR:  result = out_nor;
      isa_pkg::OP_NAND: result = out_nand;
      isa_pkg::OP_DIV4: result = out_div4;
      isa_pkg::OP_MUL2: result = out_mul2;
      isa_pkg::OP_MUL:  result = out_mul;
      default:          result = '0;
    endcase
  end

  // Controller always presents a known opcode, from reset or from memory
  always_comb begin
    assert (!$isunknown(op))
      else $error("alu_exec: opcode is unknown");
  end

endmodule

`default_nettype wire

// ==== src/reg_file.sv ====
`timescale 1ns/1ns
`default_nettype none

module reg_file (
  input  wire                clk,
  input  wire                rst_n,
  // Host write port, already qualified by not-busy
  input  wire                reg_we,
  input  isa_pkg::reg_addr_t reg_waddr,
  input  core_pkg::word_t    reg_wdata,
  // Writeback from the controller
  input  core_pkg::wb_t      wb,
  // Operand and host read addresses
  input  isa_pkg::reg_addr_t rs_addr,
  input  isa_pkg::reg_addr_t rt_addr,
  input  isa_pkg::reg_addr_t rd_addr,
  output core_pkg::word_t    rs_val,
  output core_pkg::word_t    rt_val,
  output core_pkg::word_t    rd_data
);

  core_pkg::word_t regs [isa_pkg::NUM_REGS];

  // Registers come out of reset as zero
  // Writeback wins over a host write in the same cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < isa_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.we) begin
      regs[wb.addr] <= wb.data;
    end else if (reg_we) begin
      regs[reg_waddr] <= reg_wdata;
    end
  end

  // All reads are combinational
  assign rs_val  = regs[rs_addr];
  assign rt_val  = regs[rt_addr];
  // Host readback, valid at all times
  assign rd_data = regs[rd_addr];

  // Top blocks host writes while busy, and writeback only happens while busy
  a_no_write_clash: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(reg_we && wb.we)
  ) else $error("reg_file: host write collided with writeback");

endmodule

`default_nettype wire

// ==== src/instr_mem.sv ====
`timescale 1ns/1ns
`default_nettype none

module instr_mem #(
  parameter int IMEM_DEPTH = 16
) (
  input  wire                          clk,
  // Host programming port
  input  wire                          we,
  input  wire [$clog2(IMEM_DEPTH)-1:0] waddr,
  input  isa_pkg::instr_t              wdata,
  // Fetch port, one cycle latency
  input  wire [$clog2(IMEM_DEPTH)-1:0] raddr,
  output isa_pkg::instr_t              rdata
);

  isa_pkg::instr_t mem [IMEM_DEPTH];

  // Program words start as zero, which decodes to add r0 = r0 + r0
  initial begin
    for (int i = 0; i < IMEM_DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  // Host write
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // Registered read, address in FETCH gives data in EXEC
  always_ff @(posedge clk) begin
    rdata <= mem[raddr];
  end

endmodule

`default_nettype wire

// ==== src/cpu_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_ctrl #(
  parameter int IMEM_DEPTH = 16
) (
  input  wire                            clk,
  input  wire                            rst_n,
  // Host start with number of instructions to run
  input  wire                            start,
  input  wire [$clog2(IMEM_DEPTH):0]     instr_count,
  // Program memory fetch
  output logic [$clog2(IMEM_DEPTH)-1:0]  imem_raddr,
  input  isa_pkg::instr_t                imem_rdata,
  // Decode to the datapath
  output isa_pkg::opcode_e               op,
  output isa_pkg::reg_addr_t             rs_addr,
  output isa_pkg::reg_addr_t             rt_addr,
  input  core_pkg::word_t                alu_result,
  // Registered writeback request
  output core_pkg::wb_t                  wb,
  output logic                           busy,
  output logic                           done
);

  localparam int PC_W  = $clog2(IMEM_DEPTH);
  // One more bit so a full program count fits
  localparam int CNT_W = PC_W + 1;

  core_pkg::ctrl_state_e state_q;
  core_pkg::ctrl_state_e state_d;

  logic [PC_W-1:0]  pc_q;
  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] exec_cnt_q;
  isa_pkg::instr_t  ir_q;
  isa_pkg::instr_t  cur_instr;
  core_pkg::wb_t    wb_q;
  logic             done_q;
  logic             last_instr;
  logic             start_empty;

  // Current instruction comes straight from memory in EXEC
  // Held in the instruction register afterwards so operands stay stable
  assign cur_instr = (state_q == core_pkg::EXEC) ? imem_rdata : ir_q;

  assign op      = cur_instr.op;
  assign rs_addr = cur_instr.rs;
  assign rt_addr = cur_instr.rt;

  // WB of the final instruction ends the run
  assign last_instr  = (exec_cnt_q == cnt_q - CNT_W'(1));
  // Start with a zero count completes without leaving IDLE
  assign start_empty = start && (instr_count == '0);

  always_comb begin
    state_d = state_q;
    case (state_q)
      core_pkg::IDLE: begin
        if (start && !start_empty) begin
          state_d = core_pkg::FETCH;
        end
      end
      core_pkg::FETCH: state_d = core_pkg::EXEC;
      core_pkg::EXEC:  state_d = core_pkg::WB;
      core_pkg::WB:    state_d = last_instr ? core_pkg::IDLE : core_pkg::FETCH;
      default:         state_d = core_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q    <= core_pkg::IDLE;
      pc_q       <= '0;
      cnt_q      <= '0;
      exec_cnt_q <= '0;
      ir_q       <= '0;
      wb_q       <= '0;
      done_q     <= 1'b0;
    end else begin
      state_q <= state_d;
      // Write enable is a single cycle strobe
      wb_q.we <= 1'b0;
      done_q  <= (state_q == core_pkg::IDLE && start_empty) ||
                 (state_q == core_pkg::WB && last_instr);
      case (state_q)
        core_pkg::IDLE: begin
          // Start only counts while idle
          if (start) begin
            cnt_q      <= instr_count;
            pc_q       <= '0;
            exec_cnt_q <= '0;
          end
        end
        core_pkg::EXEC: begin
          ir_q <= imem_rdata;
          // Result is held here and written to the register file during WB
          wb_q <= '{we: 1'b1, addr: imem_rdata.rd, data: alu_result};
        end
        core_pkg::WB: begin
          exec_cnt_q <= exec_cnt_q + CNT_W'(1);
          pc_q       <= pc_q + PC_W'(1);
        end
        default: begin
        end
      endcase
    end
  end

  assign imem_raddr = pc_q;
  assign wb         = wb_q;
  assign busy       = (state_q != core_pkg::IDLE);
  assign done       = done_q;

  a_done_one_cycle: assert property (
    @(posedge clk) disable iff (!rst_n)
    done |=> !done
  ) else $error("cpu_ctrl: done held longer than one cycle");

  // Register file write happens only at the close of WB
  a_wb_in_wb_only: assert property (
    @(posedge clk) disable iff (!rst_n)
    wb.we |-> state_q == core_pkg::WB
  ) else $error("cpu_ctrl: writeback outside WB");

endmodule

`default_nettype wire

// ==== src/tiny_cpu.sv ====
`timescale 1ns/1ns
`default_nettype none

module tiny_cpu #(
  parameter int IMEM_DEPTH = 16
) (
  input  wire                          clk,
  input  wire                          rst_n,
  // Program load
  input  wire                          prog_we,
  input  wire [$clog2(IMEM_DEPTH)-1:0] prog_addr,
  input  isa_pkg::instr_t              prog_instr,
  // Register preload
  input  wire                          reg_we,
  input  isa_pkg::reg_addr_t           reg_waddr,
  input  core_pkg::word_t              reg_wdata,
  // Run control
  input  wire                          start,
  input  wire [$clog2(IMEM_DEPTH):0]   instr_count,
  // Register readback
  input  isa_pkg::reg_addr_t           rd_addr,
  output core_pkg::word_t              rd_data,
  output logic                         busy,
  output logic                         done
);

  localparam int PC_W = $clog2(IMEM_DEPTH);

  logic [PC_W-1:0]    imem_raddr;
  isa_pkg::instr_t    imem_rdata;
  isa_pkg::opcode_e   op;
  isa_pkg::reg_addr_t rs_addr;
  isa_pkg::reg_addr_t rt_addr;
  core_pkg::word_t    rs_val;
  core_pkg::word_t    rt_val;
  core_pkg::word_t    alu_result;
  core_pkg::wb_t      wb;

  // Host writes are dropped while a program runs
  logic prog_we_ok;
  logic reg_we_ok;

  assign prog_we_ok = prog_we && !busy;
  assign reg_we_ok  = reg_we && !busy;

  cpu_ctrl #(
    .IMEM_DEPTH(IMEM_DEPTH)
  ) u_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .instr_count(instr_count),
    .imem_raddr (imem_raddr),
    .imem_rdata (imem_rdata),
    .op         (op),
    .rs_addr    (rs_addr),
    .rt_addr    (rt_addr),
    .alu_result (alu_result),
    .wb         (wb),
    .busy       (busy),
    .done       (done)
  );

  alu_exec u_alu (
    .op    (op),
    .rs_val(rs_val),
    .rt_val(rt_val),
    .result(alu_result)
  );

  reg_file u_regs (
    .clk      (clk),
    .rst_n    (rst_n),
    .reg_we   (reg_we_ok),
    .reg_waddr(reg_waddr),
    .reg_wdata(reg_wdata),
    .wb       (wb),
    .rs_addr  (rs_addr),
    .rt_addr  (rt_addr),
    .rd_addr  (rd_addr),
    .rs_val   (rs_val),
    .rt_val   (rt_val),
    .rd_data  (rd_data)
  );

  instr_mem #(
    .IMEM_DEPTH(IMEM_DEPTH)
  ) u_imem (
    .clk  (clk),
    .we   (prog_we_ok),
    .waddr(prog_addr),
    .wdata(prog_instr),
    .raddr(imem_raddr),
    .rdata(imem_rdata)
  );

endmodule

`default_nettype wire

// ==== dv/tb_tiny_cpu.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_tiny_cpu;

  localparam int IMEM_DEPTH = 16;
  localparam int PC_W = $clog2(IMEM_DEPTH);
  localparam int CLK_PERIOD = 100;
  localparam int SEED = 32'h55b1ecf8;
  localparam int WORD_MOD = 2 ** core_pkg::WORD_W;
  localparam int NUM_OPS = 2 ** isa_pkg::OP_W;
  localparam int NUM_RAND_PROGS = 10;
  // Two single-op runs per opcode plus the random programs and four fixed runs
  localparam int NUM_RUNS = 2 * NUM_OPS + NUM_RAND_PROGS + 4;
  localparam int WATCHDOG_CYCLES = NUM_RUNS * (3 * IMEM_DEPTH + 20) + 1000;
  // One nibble of edge operands per opcode with opcode 0 in the low nibble
  localparam logic [31:0] WRAP_A = 32'hFBFFAF2F;
  localparam logic [31:0] WRAP_B = 32'hF00F5093;

  typedef logic [PC_W-1:0] pc_t;
  typedef logic [PC_W:0] cnt_t;

  logic               clk = 1'b0;
  logic               rst_n;
  logic               prog_we;
  pc_t                prog_addr;
  isa_pkg::instr_t    prog_instr;
  logic               reg_we;
  isa_pkg::reg_addr_t reg_waddr;
  core_pkg::word_t    reg_wdata;
  logic               start;
  cnt_t               instr_count;
  isa_pkg::reg_addr_t rd_addr;
  core_pkg::word_t    rd_data;
  logic               busy;
  logic               done;

  // Mirrors of the register file and program memory
  core_pkg::word_t model [isa_pkg::NUM_REGS];
  isa_pkg::instr_t prog [IMEM_DEPTH];
  int cycle = 0;
  int err_cnt = 0;
  int tests_ok = 0;
  int tests_bad = 0;

  tiny_cpu #(.IMEM_DEPTH(IMEM_DEPTH)) u_dut (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) cycle <= cycle + 1;

  // Done pulse only ever seen with busy low
  a_done_idle: assert property (@(posedge clk) disable iff (!rst_n) done |-> !busy)
    else begin
      $display("[ERROR] %0t done high while busy", $time);
      err_cnt++;
    end

  // Every run that raised busy ends in done
  a_fall_done: assert property (@(posedge clk) disable iff (!rst_n) $fell(busy) |-> done)
    else begin
      $display("[ERROR] %0t busy fell without done", $time);
      err_cnt++;
    end

  // Reference ALU in integer arithmetic reduced modulo the word range
  function automatic core_pkg::word_t alu_ref(isa_pkg::opcode_e op, core_pkg::word_t a,
                                              core_pkg::word_t b);
    int x;
    int y;
    int r;
    x = int'(a);
    y = int'(b);
    case (op)
      isa_pkg::OP_ADD:  r = (x + y) % WORD_MOD;
      isa_pkg::OP_SUB:  r = (x - y + WORD_MOD) % WORD_MOD;
      isa_pkg::OP_INC:  r = (x + 1) % WORD_MOD;
      isa_pkg::OP_NOR:  r = WORD_MOD - 1 - (x | y);
      isa_pkg::OP_NAND: r = WORD_MOD - 1 - (x & y);
      isa_pkg::OP_DIV4: r = x / 4;
      isa_pkg::OP_MUL2: r = (x * 2) % WORD_MOD;
      default:          r = (x * y) % WORD_MOD;
    endcase
    return core_pkg::word_t'(r);
  endfunction

  function automatic isa_pkg::instr_t rand_instr();
    isa_pkg::instr_t ins;
    ins.op = isa_pkg::opcode_e'($urandom_range(0, NUM_OPS - 1));
    ins.rd = isa_pkg::reg_addr_t'($urandom);
    ins.rs = isa_pkg::reg_addr_t'($urandom);
    ins.rt = isa_pkg::reg_addr_t'($urandom);
    return ins;
  endfunction

  task automatic write_reg(input int addr, input core_pkg::word_t data);
    reg_we = 1'b1;
    reg_waddr = isa_pkg::reg_addr_t'(addr);
    reg_wdata = data;
    @(posedge clk);
    #1;
    reg_we = 1'b0;
    model[addr] = data;
  endtask

  task automatic write_instr(input int addr, input isa_pkg::instr_t ins);
    prog_we = 1'b1;
    prog_addr = pc_t'(addr);
    prog_instr = ins;
    @(posedge clk);
    #1;
    prog_we = 1'b0;
    prog[addr] = ins;
  endtask

  task automatic preload_regs();
    for (int r = 0; r < isa_pkg::NUM_REGS; r++) begin
      write_reg(r, core_pkg::word_t'($urandom));
    end
  endtask

  // Odd slots read the previous destination for a back-to-back dependency
  task automatic load_rand_prog(input int n);
    isa_pkg::instr_t ins;
    for (int i = 0; i < n; i++) begin
      ins = rand_instr();
      if (i % 2 == 1) ins.rs = prog[i-1].rd;
      write_instr(i, ins);
    end
  endtask

  // One register per cycle with the read address driven just after the edge
  task automatic check_regs();
    for (int r = 0; r < isa_pkg::NUM_REGS; r++) begin
      rd_addr = isa_pkg::reg_addr_t'(r);
      #1;
      assert (rd_data == model[r])
        else begin
          $display("[ERROR] %0t r%0d reads %h, expected %h", $time, r, rd_data, model[r]);
          err_cnt++;
        end
      @(posedge clk);
      #1;
    end
  endtask

  // Start n instructions and time the run before stepping the model
  // Noisy runs fire host writes and start only in cycles seen busy
  task automatic run_prog(input int n, input bit noisy);
    int c0;
    int busy_cycles;
    bit finished;
    isa_pkg::instr_t ins;
    busy_cycles = 0;
    finished = 1'b0;
    start = 1'b1;
    instr_count = cnt_t'(n);
    c0 = cycle;
    while (!finished) begin
      @(posedge clk);
      #1;
      start = 1'b0;
      reg_we = 1'b0;
      prog_we = 1'b0;
      if (busy) busy_cycles++;
      finished = done || (cycle - c0 > 3 * n + 10);
      if (noisy && busy && !finished) begin
        reg_we = 1'b1;
        reg_waddr = isa_pkg::reg_addr_t'($urandom);
        reg_wdata = core_pkg::word_t'($urandom);
        prog_we = 1'b1;
        prog_addr = pc_t'($urandom);
        prog_instr = rand_instr();
        start = 1'b1;
        instr_count = cnt_t'($urandom);
      end
    end
    assert (done)
      else begin
        $display("Timeout: done never came after a start with count %0d", n);
        err_cnt++;
      end
    assert (cycle - c0 == 3 * n + 1)
      else begin
        $display("[ERROR] %0t start to done took %0d cycles, expected %0d", $time,
                 cycle - c0, 3 * n + 1);
        err_cnt++;
      end
    assert (busy_cycles == 3 * n)
      else begin
        $display("[ERROR] %0t busy for %0d cycles, expected %0d", $time, busy_cycles, 3 * n);
        err_cnt++;
      end
    for (int i = 0; i < n; i++) begin
      ins = prog[i];
      model[ins.rd] = alu_ref(ins.op, model[ins.rs], model[ins.rt]);
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    if (err_cnt == errs_before) begin
      tests_ok++;
      $display("test %s: ok", name);
    end else begin
      tests_bad++;
      $display("test %s: failed with %0d errors", name, err_cnt - errs_before);
    end
  endtask

  initial begin
    isa_pkg::instr_t ins;
    int e0;
    int n;
    void'($urandom(SEED));
    rst_n = 1'b0;
    prog_we = 1'b0;
    prog_addr = '0;
    prog_instr = '0;
    reg_we = 1'b0;
    reg_waddr = '0;
    reg_wdata = '0;
    start = 1'b0;
    instr_count = '0;
    rd_addr = '0;
    for (int r = 0; r < isa_pkg::NUM_REGS; r++) model[r] = '0;
    for (int i = 0; i < IMEM_DEPTH; i++) prog[i] = '0;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;

    e0 = err_cnt;
    assert (!busy && !done)
      else begin
        $display("[ERROR] %0t busy or done is high straight after reset", $time);
        err_cnt++;
      end
    check_regs();
    end_test("reset state", e0);

    // Random operands in the first pass and wrap operands in the second
    e0 = err_cnt;
    for (int k = 0; k < 2 * NUM_OPS; k++) begin
      ins.op = isa_pkg::opcode_e'(k % NUM_OPS);
      ins.rd = isa_pkg::reg_addr_t'($urandom);
      ins.rs = isa_pkg::reg_addr_t'(1);
      ins.rt = isa_pkg::reg_addr_t'(2);
      preload_regs();
      if (k >= NUM_OPS) begin
        write_reg(1, core_pkg::word_t'(WRAP_A >> (core_pkg::WORD_W * (k % NUM_OPS))));
        write_reg(2, core_pkg::word_t'(WRAP_B >> (core_pkg::WORD_W * (k % NUM_OPS))));
      end
      write_instr(0, ins);
      run_prog(1, 1'b0);
      check_regs();
    end
    end_test("each opcode", e0);

    e0 = err_cnt;
    for (int p = 0; p < NUM_RAND_PROGS; p++) begin
      n = $urandom_range(1, IMEM_DEPTH);
      load_rand_prog(n);
      preload_regs();
      run_prog(n, 1'b0);
      check_regs();
    end
    end_test("random programs", e0);

    // Zero count followed by a full program
    e0 = err_cnt;
    run_prog(0, 1'b0);
    check_regs();
    load_rand_prog(IMEM_DEPTH);
    run_prog(IMEM_DEPTH, 1'b0);
    check_regs();
    end_test("timing", e0);

    // Rerun proves the program words survived the noise
    e0 = err_cnt;
    load_rand_prog(IMEM_DEPTH);
    preload_regs();
    run_prog(IMEM_DEPTH, 1'b1);
    check_regs();
    run_prog(IMEM_DEPTH, 1'b0);
    check_regs();
    end_test("writes while busy", e0);

    $display("tests ok: %0d, tests failed: %0d, errors: %0d", tests_ok, tests_bad, err_cnt);
    if (err_cnt == 0 && tests_bad == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
src/isa_pkg.sv
src/core_pkg.sv
src/alu_exec.sv
src/reg_file.sv
src/instr_mem.sv
src/cpu_ctrl.sv
src/tiny_cpu.sv
dv/tb_tiny_cpu.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_tiny_cpu -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "^SIMULATION PASSED$" sim.log; then
  exit 0
fi
exit 1
